// File: common/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // ********************
    // widths
    // ********************
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_BITS    = 5;   // byte offset within a line
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [LINE_W-1:0]     line_t;    // word 0 sits in the low bits
    typedef logic [WORD_W/8-1:0]   mask_t;    // one enable per byte lane

    // ********************
    // encodings
    // ********************
    typedef enum logic [1:0] {
        SIZE_WORD = 2'd0,
        SIZE_BYTE = 2'd1,
        SIZE_HALF = 2'd2
    } size_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE_BACK,   // dirty victim going out
        ST_REFILL        // new line coming in
    } state_e;

endpackage

`default_nettype wire

// File: verilog/store_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_align (
    input  dcache_pkg::addr_t addr,
    input  dcache_pkg::word_t wr_data,
    input  dcache_pkg::size_e wr_size,
    output dcache_pkg::mask_t byte_mask,
    output dcache_pkg::word_t lane_data
);
    import dcache_pkg::*;

    // little-endian lanes, addr[1:0] picks the lane
    always_comb begin
        case (wr_size)
            SIZE_BYTE: begin
                byte_mask = mask_t'(1) << addr[1:0];
                lane_data = {4{wr_data[7:0]}};   // same byte in every lane
            end
            SIZE_HALF: begin
                byte_mask = mask_t'(2'b11) << {addr[1], 1'b0};
                lane_data = {2{wr_data[15:0]}};
            end
            default: begin   // full word
                byte_mask = '1;
                lane_data = wr_data;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: cache_array/tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module tag_store #(
    parameter int INDEX_BITS = 9
) (
    input  wire               CLK,
    input  wire               RESET,
    input  dcache_pkg::addr_t addr,
    input  wire               fill,
    input  wire               mark_dirty,
    output logic              hit,
    output logic              hit_way,
    output logic              victim_way,
    output logic              victim_dirty,
    output dcache_pkg::addr_t victim_addr
);
    import dcache_pkg::*;

    localparam int SETS  = 1 << INDEX_BITS;
    localparam int TAG_W = ADDR_W - INDEX_BITS - OFFSET_BITS;

    logic [INDEX_BITS-1:0] idx;
    logic [TAG_W-1:0]      tag;
    logic [1:0]            way_hit;

    logic [1:0][SETS-1:0]  valid_q;
    logic [1:0][SETS-1:0]  dirty_q;
    logic [SETS-1:0]       victim_q;   // 0 evicts way 0, 1 evicts way 1
    logic [TAG_W-1:0]      tag_mem [2][SETS];

    assign idx = addr[OFFSET_BITS +: INDEX_BITS];
    assign tag = addr[ADDR_W-1 -: TAG_W];

    // ********************
    // lookup
    // ********************
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][idx] && (tag_mem[w][idx] == tag);
        end
    end

    assign hit          = |way_hit;
    assign hit_way      = way_hit[1];
    assign victim_way   = victim_q[idx];
    assign victim_dirty = dirty_q[victim_way][idx];
    assign victim_addr  = {tag_mem[victim_way][idx], idx, {OFFSET_BITS{1'b0}}};

    // ********************
    // state bits
    // ********************
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            valid_q  <= '0;
            dirty_q  <= '0;
            victim_q <= '0;
        end else if (fill) begin
            valid_q[victim_way][idx] <= 1'b1;
            dirty_q[victim_way][idx] <= 1'b0;      // fresh from dram
            victim_q[idx]            <= ~victim_q[idx];   // round robin
        end else if (mark_dirty) begin
            dirty_q[hit_way][idx] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (fill) tag_mem[victim_way][idx] <= tag;
    end

endmodule

`default_nettype wire

// File: cache_array/data_store.sv
`timescale 1ns/1ps
`default_nettype none

module data_store #(
    parameter int INDEX_BITS = 9
) (
    input  wire               CLK,
    input  dcache_pkg::addr_t addr,
    input  wire               hit_way,
    input  wire               victim_way,
    input  wire               store_en,
    input  dcache_pkg::mask_t byte_mask,
    input  dcache_pkg::word_t lane_data,
    input  wire               fill,
    input  dcache_pkg::line_t fill_line,
    output dcache_pkg::word_t rd_data,
    output dcache_pkg::line_t victim_line
);
    import dcache_pkg::*;

    localparam int SETS   = 1 << INDEX_BITS;
    localparam int WSEL_W = $clog2(WORDS_PER_LINE);

    logic [INDEX_BITS-1:0] idx;
    logic [WSEL_W-1:0]     word_sel;

    // two ways, one line of words per set
    word_t line_mem [2][SETS][WORDS_PER_LINE];

    assign idx      = addr[OFFSET_BITS +: INDEX_BITS];
    assign word_sel = addr[2 +: WSEL_W];

    always_ff @(posedge CLK) begin
        if (fill) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                line_mem[victim_way][idx][w] <= fill_line[w*WORD_W +: WORD_W];
            end
        end else if (store_en) begin
            for (int b = 0; b < WORD_W/8; b++) begin
                if (byte_mask[b]) begin
                    line_mem[hit_way][idx][word_sel][b*8 +: 8] <= lane_data[b*8 +: 8];
                end
            end
        end
    end

    assign rd_data = line_mem[hit_way][idx][word_sel];   // hit way word

    // whole victim line for the write-back
    always_comb begin
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            victim_line[w*WORD_W +: WORD_W] = line_mem[victim_way][idx][w];
        end
    end

endmodule

`default_nettype wire

// File: miss_ctrl/miss_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module miss_fsm (
    input  wire                CLK,
    input  wire                RESET,
    input  wire                req,
    input  wire                wren,
    input  wire                hit,
    input  wire                victim_dirty,
    input  wire                dram_wr_done,
    input  wire                refill_last,
    output dcache_pkg::state_e state,
    output logic               store_en,
    output logic               mark_dirty,
    output logic               stall,
    output logic               dram_wr_req,
    output logic               dram_rd_req
);
    import dcache_pkg::*;

    state_e next_state;
    logic   idle;
    logic   miss;
    logic   write_hit;

    assign idle      = (state == ST_IDLE);
    assign miss      = req && !hit;
    assign write_hit = idle && req && wren && hit;

    // ********************
    // next state
    // ********************
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (miss) begin
                    // dirty victim has to go out first
                    next_state = victim_dirty ? ST_WRITE_BACK : ST_REFILL;
                end
            end
            ST_WRITE_BACK: begin
                if (dram_wr_done) next_state = ST_REFILL;
            end
            ST_REFILL: begin
                if (refill_last) next_state = ST_IDLE;   // line installed this edge
            end
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ********************
    // outputs
    // ********************
    assign store_en    = write_hit;
    assign mark_dirty  = write_hit;   // store dirties the hit line
    assign stall       = miss || !idle;
    assign dram_wr_req = (state == ST_WRITE_BACK);
    assign dram_rd_req = (state == ST_REFILL);

endmodule

`default_nettype wire

// File: miss_ctrl/dram_port.sv
`timescale 1ns/1ps
`default_nettype none

module dram_port (
    input  wire               CLK,
    input  wire               RESET,
    input  dcache_pkg::addr_t addr,
    input  wire               dram_rd_req,
    input  dcache_pkg::word_t dram_rd_data,
    input  wire               dram_rd_valid,
    output dcache_pkg::addr_t dram_rd_addr,
    output logic              refill_last,
    output logic              fill,
    output dcache_pkg::line_t fill_line
);
    import dcache_pkg::*;

    localparam int BEAT_W = $clog2(WORDS_PER_LINE);

    logic [BEAT_W-1:0] beat;
    logic              beat_ok;
    // first seven words, the last one comes straight from the bus
    word_t             shift_buf [WORDS_PER_LINE-1];

    assign beat_ok      = dram_rd_req && dram_rd_valid;
    assign refill_last  = beat_ok && (beat == BEAT_W'(WORDS_PER_LINE - 1));
    assign fill         = refill_last;
    assign dram_rd_addr = {addr[ADDR_W-1:OFFSET_BITS], beat, 2'b00};

    // beat counter
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            beat <= '0;
        end else if (refill_last) begin
            beat <= '0;             // ready for next refill
        end else if (beat_ok) begin
            beat <= beat + 1'b1;
        end
    end

    // new word enters at the top, oldest drifts down to entry 0
    always_ff @(posedge CLK) begin
        if (beat_ok) begin
            for (int i = 0; i < WORDS_PER_LINE - 2; i++) begin
                shift_buf[i] <= shift_buf[i+1];
            end
            shift_buf[WORDS_PER_LINE-2] <= dram_rd_data;
        end
    end

    always_comb begin
        for (int i = 0; i < WORDS_PER_LINE - 1; i++) begin
            fill_line[i*WORD_W +: WORD_W] = shift_buf[i];
        end
        fill_line[LINE_W-1 -: WORD_W] = dram_rd_data;   // eighth word
    end

endmodule

`default_nettype wire

// File: verilog/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int INDEX_BITS = 9
) (
    input  wire               CLK,
    input  wire               RESET,
    // processor side
    input  wire               req,
    input  wire               wren,
    input  dcache_pkg::addr_t addr,
    input  dcache_pkg::word_t wr_data,
    input  dcache_pkg::size_e wr_size,
    output dcache_pkg::word_t rd_data,
    output logic              hit,
    output logic              stall,
    // dram write-back
    output logic              dram_wr_req,
    output dcache_pkg::addr_t dram_wr_addr,
    output dcache_pkg::line_t dram_wr_line,
    input  wire               dram_wr_done,
    // dram refill
    output logic              dram_rd_req,
    output dcache_pkg::addr_t dram_rd_addr,
    input  dcache_pkg::word_t dram_rd_data,
    input  wire               dram_rd_valid
);
    import dcache_pkg::*;

    mask_t byte_mask;
    word_t lane_data;
    logic  hit_way;
    logic  victim_way;
    logic  victim_dirty;
    logic  store_en;
    logic  mark_dirty;
    logic  refill_last;
    logic  fill;
    line_t fill_line;

    // ********************
    // datapath
    // ********************
    store_align u_store_align (
        .addr      (addr),
        .wr_data   (wr_data),
        .wr_size   (wr_size),
        .byte_mask (byte_mask),
        .lane_data (lane_data)
    );

    tag_store #(.INDEX_BITS(INDEX_BITS)) u_tag_store (
        .CLK          (CLK),
        .RESET        (RESET),
        .addr         (addr),
        .fill         (fill),
        .mark_dirty   (mark_dirty),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_addr  (dram_wr_addr)   // write-back goes to the victim's line
    );

    data_store #(.INDEX_BITS(INDEX_BITS)) u_data_store (
        .CLK         (CLK),
        .addr        (addr),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .store_en    (store_en),
        .byte_mask   (byte_mask),
        .lane_data   (lane_data),
        .fill        (fill),
        .fill_line   (fill_line),
        .rd_data     (rd_data),
        .victim_line (dram_wr_line)
    );

    // ********************
    // miss handling
    // ********************
    miss_fsm u_miss_fsm (
        .CLK          (CLK),
        .RESET        (RESET),
        .req          (req),
        .wren         (wren),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .dram_wr_done (dram_wr_done),
        .refill_last  (refill_last),
        .state        (),
        .store_en     (store_en),
        .mark_dirty   (mark_dirty),
        .stall        (stall),
        .dram_wr_req  (dram_wr_req),
        .dram_rd_req  (dram_rd_req)
    );

    dram_port u_dram_port (
        .CLK           (CLK),
        .RESET         (RESET),
        .addr          (addr),
        .dram_rd_req   (dram_rd_req),
        .dram_rd_data  (dram_rd_data),
        .dram_rd_valid (dram_rd_valid),
        .dram_rd_addr  (dram_rd_addr),
        .refill_last   (refill_last),
        .fill          (fill),
        .fill_line     (fill_line)
    );

endmodule

`default_nettype wire

// File: sim/dram_model.sv
`timescale 1ns/1ps
`default_nettype none

module dram_model (
    input  wire               CLK,
    input  wire               RESET,
    input  wire               dram_wr_req,
    input  dcache_pkg::addr_t dram_wr_addr,
    input  dcache_pkg::line_t dram_wr_line,
    output logic              dram_wr_done,
    input  wire               dram_rd_req,
    input  dcache_pkg::addr_t dram_rd_addr,
    output dcache_pkg::word_t dram_rd_data,
    output logic              dram_rd_valid,
    output int                wb_count,
    output dcache_pkg::addr_t last_wb_addr
);
    import dcache_pkg::*;

    integer seed = 32'h24f0_bed7;
    int     wait_cycles;
    word_t  mem [addr_t];   // keyed by word-aligned byte address

    // never written words hold a pattern of their own address
    function automatic word_t read_word(input addr_t a);
        addr_t wa;
        wa = {a[ADDR_W-1:2], 2'b00};
        if (mem.exists(wa)) begin
            return mem[wa];
        end
        return wa ^ 32'h5a5a_0000;
    endfunction

    // answers move on the falling edge, the cache samples on the rising one
    always @(negedge CLK or negedge RESET) begin
        if (!RESET) begin
            dram_wr_done  <= 1'b0;
            dram_rd_valid <= 1'b0;
            dram_rd_data  <= '0;
            wb_count      <= 0;
            last_wb_addr  <= '0;
            wait_cycles   = 0;
        end else begin
            dram_wr_done  <= 1'b0;   // single cycle pulses
            dram_rd_valid <= 1'b0;
            if (dram_wr_req || dram_rd_req) begin
                if (wait_cycles > 0) begin
                    wait_cycles = wait_cycles - 1;
                end else if (dram_wr_req) begin
                    for (int w = 0; w < WORDS_PER_LINE; w++) begin
                        mem[dram_wr_addr + 32'(4 * w)] = dram_wr_line[w*WORD_W +: WORD_W];
                    end
                    wb_count     <= wb_count + 1;
                    last_wb_addr <= dram_wr_addr;
                    dram_wr_done <= 1'b1;
                    wait_cycles  = {$random(seed)} % 4;
                end else begin
                    dram_rd_data  <= read_word(dram_rd_addr);
                    dram_rd_valid <= 1'b1;
                    wait_cycles   = {$random(seed)} % 4;   // gap before next beat
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int INDEX_BITS     = 2;      // four sets with a 128-byte stride
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = 4000;   // 18 accesses of up to ~40 cycles each
    localparam int EXPECTED_READS = 13;

    logic  CLK;
    logic  RESET;
    logic  req;
    logic  wren;
    addr_t addr;
    word_t wr_data;
    size_e wr_size;
    word_t rd_data;
    logic  hit;
    logic  stall;
    logic  dram_wr_req;
    addr_t dram_wr_addr;
    line_t dram_wr_line;
    logic  dram_wr_done;
    logic  dram_rd_req;
    addr_t dram_rd_addr;
    word_t dram_rd_data;
    logic  dram_rd_valid;
    int    wb_count;
    addr_t last_wb_addr;

    int         errors = 0;
    int         checks = 0;
    int         reads_checked = 0;
    int         cycle_count = 0;
    int         stall_cycles;      // of the last access
    logic       refill_seen;       // last access went to dram
    int         wb_before;
    string      test_name;
    logic [7:0] shadow [addr_t];   // bytes stored so far

    dcache_top #(.INDEX_BITS(INDEX_BITS)) dut (
        .CLK(CLK), .RESET(RESET), .req(req), .wren(wren), .addr(addr),
        .wr_data(wr_data), .wr_size(wr_size), .rd_data(rd_data), .hit(hit), .stall(stall),
        .dram_wr_req(dram_wr_req), .dram_wr_addr(dram_wr_addr),
        .dram_wr_line(dram_wr_line), .dram_wr_done(dram_wr_done),
        .dram_rd_req(dram_rd_req), .dram_rd_addr(dram_rd_addr),
        .dram_rd_data(dram_rd_data), .dram_rd_valid(dram_rd_valid)
    );

    dram_model u_dram (
        .CLK(CLK), .RESET(RESET),
        .dram_wr_req(dram_wr_req), .dram_wr_addr(dram_wr_addr),
        .dram_wr_line(dram_wr_line), .dram_wr_done(dram_wr_done),
        .dram_rd_req(dram_rd_req), .dram_rd_addr(dram_rd_addr),
        .dram_rd_data(dram_rd_data), .dram_rd_valid(dram_rd_valid),
        .wb_count(wb_count), .last_wb_addr(last_wb_addr)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // ********************
    // reference and checks
    // ********************
    function automatic word_t expect_word(input addr_t a);
        addr_t base;
        word_t w;
        base = {a[ADDR_W-1:2], 2'b00};
        w    = base ^ 32'h5a5a_0000;   // untouched memory pattern
        for (int b = 0; b < 4; b++) begin
            if (shadow.exists(base + 32'(b))) begin
                w[b*8 +: 8] = shadow[base + 32'(b)];
            end
        end
        return w;
    endfunction

    // little-endian byte placement of a store
    task automatic record_store(input addr_t a, input word_t d, input size_e s);
        case (s)
            SIZE_BYTE: shadow[a] = d[7:0];
            SIZE_HALF: begin
                shadow[{a[ADDR_W-1:1], 1'b0}] = d[7:0];
                shadow[{a[ADDR_W-1:1], 1'b1}] = d[15:8];
            end
            default: begin
                for (int b = 0; b < 4; b++) begin
                    shadow[{a[ADDR_W-1:2], 2'b00} + 32'(b)] = d[b*8 +: 8];
                end
            end
        endcase
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // every read that completes on this edge
    always @(posedge CLK) begin
        if (RESET && req && !wren && !stall) begin
            reads_checked++;
            check_value({test_name, " hit"}, 32'd1, 32'(hit));
            check_value({test_name, " read data"}, expect_word(addr), rd_data);
        end
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ********************
    // processor side
    // ********************
    task automatic access(input logic we, input addr_t a, input word_t d, input size_e s);
        @(negedge CLK);
        req     = 1'b1;
        wren    = we;
        addr    = a;
        wr_data = d;
        wr_size = s;
        stall_cycles = 0;
        #1;
        refill_seen = dram_rd_req;
        while (stall) begin   // request held for the whole miss
            stall_cycles++;
            @(negedge CLK);
            refill_seen = refill_seen | dram_rd_req;
        end
        @(posedge CLK);       // completes on this edge
        if (we) begin
            record_store(a, d, s);
        end
        @(negedge CLK);
        req  = 1'b0;
        wren = 1'b0;
    endtask

    task automatic load(input addr_t a);
        access(1'b0, a, '0, SIZE_WORD);
    endtask

    task automatic store(input addr_t a, input word_t d, input size_e s);
        access(1'b1, a, d, s);
    endtask

    initial begin
        RESET     = 1'b0;
        req       = 1'b0;
        wren      = 1'b0;
        addr      = '0;
        wr_data   = '0;
        wr_size   = SIZE_WORD;
        test_name = "reset";
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b1;

        test_name = "read_miss";
        wb_before = wb_count;
        load(32'h0000_1004);
        check_value("read_miss refill", 32'd1, 32'(refill_seen));
        check_value("read_miss write-backs", 32'd0, 32'(wb_count - wb_before));

        test_name = "read_hit";
        load(32'h0000_1010);
        check_value("read_hit stall cycles", 32'd0, 32'(stall_cycles));
        check_value("read_hit dram_rd_req", 32'd0, 32'(refill_seen));

        test_name = "store_merge";
        store(32'h0000_1005, 32'h0000_00a5, SIZE_BYTE);
        load(32'h0000_1004);
        store(32'h0000_100a, 32'h0000_beef, SIZE_HALF);
        load(32'h0000_1008);
        store(32'h0000_100c, 32'h1234_5678, SIZE_WORD);
        load(32'h0000_100c);
        store(32'h0000_1007, 32'h0000_003c, SIZE_BYTE);
        load(32'h0000_1004);
        check_value("store_merge stall cycles", 32'd0, 32'(stall_cycles));

        // set 0 holds dirty 0x1000 in way 0
        test_name = "evict";
        wb_before = wb_count;
        load(32'h0000_1080);   // into way 1
        check_value("evict clean fill write-backs", 32'd0, 32'(wb_count - wb_before));
        wb_before = wb_count;
        load(32'h0000_1100);   // pointer back on way 0
        check_value("evict dirty write-backs", 32'd1, 32'(wb_count - wb_before));
        check_value("evict write-back address", 32'h0000_1000, last_wb_addr);
        wb_before = wb_count;
        load(32'h0000_1180);   // clean 0x1080 leaves
        check_value("evict clean write-backs", 32'd0, 32'(wb_count - wb_before));

        test_name = "refetch";
        load(32'h0000_1004);
        check_value("refetch refill", 32'd1, 32'(refill_seen));
        load(32'h0000_1008);
        load(32'h0000_100c);

        test_name = "store_miss";
        store(32'h0000_2042, 32'h0000_c0de, SIZE_HALF);
        check_value("store_miss refill", 32'd1, 32'(refill_seen));
        load(32'h0000_2040);

        repeat (2) @(posedge CLK);
        check_value("reads compared", 32'(EXPECTED_READS), 32'(reads_checked));
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
common/dcache_pkg.sv
verilog/store_align.sv
cache_array/tag_store.sv
cache_array/data_store.sv
miss_ctrl/miss_fsm.sv
miss_ctrl/dram_port.sv
verilog/dcache_top.sv
sim/dram_model.sv
sim/dcache_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module dcache_tb -o dcache_sim \
    && ./obj_dir/dcache_sim | tee /dev/stderr | grep -q "Result: PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
